/* hdl/matrix_pkg.sv */
package matrix_pkg;

   // element and address widths
   localparam int DATA_W = 16;
   localparam int ADDR_W = 12;

   // row and column counts, up to 63 each
   localparam int DIM_W = 6;

   // one word per address
   localparam int MEM_DEPTH = 4096;

   // signed matrix element
   typedef logic signed [DATA_W-1:0] elem_t;

   // scratchpad word address
   typedef logic [ADDR_W-1:0] addr_t;

   // row or column count
   typedef logic [DIM_W-1:0] dim_t;

   // relu engine states
   typedef enum logic [1:0] {
      // waiting, done high
      RELU_IDLE   = 2'd0,
      // one read issued per cycle
      RELU_STREAM = 2'd1,
      // writes still in flight
      RELU_DRAIN  = 2'd2,
      // raise done next edge
      RELU_FINISH = 2'd3
   } relu_state_t;

endpackage

/* hdl/mem_port_if.sv */
`timescale 1ns/1ns

interface mem_port_if;
   import matrix_pkg::*;

   // read side, data one clock after the address
   addr_t rd_address;
   elem_t rd_data;

   // write side, written at the edge where wr_en is high
   addr_t wr_address;
   elem_t wr_data;
   logic  wr_en;

   modport requester (
      output rd_address,
      input  rd_data,
      output wr_address,
      output wr_data,
      output wr_en
   );

   modport memory (
      input  rd_address,
      output rd_data,
      input  wr_address,
      input  wr_data,
      input  wr_en
   );

endinterface

/* hdl/matrix_scratchpad.sv */
`timescale 1ns/1ns

module matrix_scratchpad (
   input logic clk,
   mem_port_if.memory mem
);
   import matrix_pkg::*;

   // word storage
   elem_t ram [MEM_DEPTH];

   // registered read word
   elem_t rd_q;

   // write port
   always_ff @(posedge clk) begin
      if (mem.wr_en) begin
         ram[mem.wr_address] <= mem.wr_data;
      end
   end

   // read port, old word on a same-address collision
   always_ff @(posedge clk) begin
      rd_q <= ram[mem.rd_address];
   end

   assign mem.rd_data = rd_q;

endmodule

/* hdl/host_port_arbiter.sv */
`timescale 1ns/1ns

module host_port_arbiter (
   input  logic clk,
   input  logic reset,
   input  logic engine_busy,
   input  matrix_pkg::addr_t host_address,
   input  matrix_pkg::elem_t host_writedata,
   input  logic host_write_en,
   output matrix_pkg::elem_t host_readdata,
   mem_port_if.memory eng,
   mem_port_if.requester mem
);

   // owner of the read issued last cycle
   logic rd_owner_eng;

   always_ff @(posedge clk) begin
      if (reset) begin
         rd_owner_eng <= 1'b0;
      end else begin
         rd_owner_eng <= engine_busy;
      end
   end

   // host uses one address for both ports while idle
   always_comb begin
      if (engine_busy) begin
         mem.rd_address = eng.rd_address;
         mem.wr_address = eng.wr_address;
         mem.wr_data    = eng.wr_data;
         mem.wr_en      = eng.wr_en;
      end else begin
         mem.rd_address = host_address;
         mem.wr_address = host_address;
         mem.wr_data    = host_writedata;
         mem.wr_en      = host_write_en;
      end
   end

   // return data to whoever asked, even across a hand-over
   assign eng.rd_data   = rd_owner_eng ? mem.rd_data : '0;
   assign host_readdata = rd_owner_eng ? '0 : mem.rd_data;

endmodule

/* hdl/matrix_relu.sv */
`timescale 1ns/1ns

module matrix_relu (
   input  logic clk,
   input  logic reset,
   input  logic start,
   output logic done,
   input  matrix_pkg::addr_t src_start_address,
   input  matrix_pkg::addr_t dest_start_address,
   input  matrix_pkg::dim_t row_size,
   input  matrix_pkg::dim_t col_size,
   mem_port_if.requester mem
);
   import matrix_pkg::*;

   relu_state_t state;

   // sizes latched at start
   dim_t row_q;
   dim_t col_q;

   // position in the matrix
   dim_t row_cnt;
   dim_t col_cnt;

   // running read and write pointers
   addr_t rd_ptr;
   addr_t wr_ptr;

   // stage 1, ram read in flight
   logic  s1_valid;
   addr_t s1_dest;

   // stage 2, clamped result
   logic  wr_valid;
   addr_t wr_addr_q;
   elem_t wr_data_q;

   logic size_zero;
   logic last_elem;
   logic issue;
   logic accept;

   assign size_zero = (row_q == '0) || (col_q == '0);
   assign last_elem = (row_cnt == row_q - dim_t'(1)) && (col_cnt == col_q - dim_t'(1));
   assign issue     = (state == RELU_STREAM) && !size_zero;
   assign accept    = (state == RELU_IDLE) && start;

   // control FSM
   always_ff @(posedge clk) begin
      if (reset) begin
         state   <= RELU_IDLE;
         done    <= 1'b1;
         row_q   <= '0;
         col_q   <= '0;
         row_cnt <= '0;
         col_cnt <= '0;
      end else begin
         case (state)
            RELU_IDLE: begin
               if (start) begin
                  state   <= RELU_STREAM;
                  done    <= 1'b0;
                  row_q   <= row_size;
                  col_q   <= col_size;
                  row_cnt <= '0;
                  col_cnt <= '0;
               end
            end
            RELU_STREAM: begin
               if (size_zero) begin
                  // nothing to do, skip the drain
                  state <= RELU_FINISH;
               end else if (last_elem) begin
                  state <= RELU_DRAIN;
               end else if (col_cnt == col_q - dim_t'(1)) begin
                  col_cnt <= '0;
                  row_cnt <= row_cnt + dim_t'(1);
               end else begin
                  col_cnt <= col_cnt + dim_t'(1);
               end
            end
            RELU_DRAIN: begin
               // last write retires on this edge once stage 1 is empty
               if (!s1_valid) begin
                  state <= RELU_FINISH;
               end
            end
            RELU_FINISH: begin
               state <= RELU_IDLE;
               done  <= 1'b1;
            end
            default: begin
               state <= RELU_IDLE;
               done  <= 1'b1;
            end
         endcase
      end
   end

   // address walk, one element per cycle
   always_ff @(posedge clk) begin
      if (accept) begin
         rd_ptr <= src_start_address;
         wr_ptr <= dest_start_address;
      end else if (issue) begin
         rd_ptr <= rd_ptr + addr_t'(1);
         wr_ptr <= wr_ptr + addr_t'(1);
      end
   end

   // valid bits of the two stages
   always_ff @(posedge clk) begin
      if (reset) begin
         s1_valid <= 1'b0;
         wr_valid <= 1'b0;
      end else begin
         s1_valid <= issue;
         wr_valid <= s1_valid;
      end
   end

   // destination travels with the data
   always_ff @(posedge clk) begin
      s1_dest <= wr_ptr;
      if (s1_valid) begin
         wr_addr_q <= s1_dest;
         // negative elements clamp to zero
         wr_data_q <= mem.rd_data[DATA_W-1] ? '0 : mem.rd_data;
      end
   end

   assign mem.rd_address = rd_ptr;
   assign mem.wr_address = wr_addr_q;
   assign mem.wr_data    = wr_data_q;
   assign mem.wr_en      = wr_valid;

endmodule

/* hdl/matrix_unit_top.sv */
`timescale 1ns/1ns

module matrix_unit_top (
   input  logic clk,
   input  logic reset,
   input  logic start,
   output logic done,
   input  matrix_pkg::addr_t src_start_address,
   input  matrix_pkg::addr_t dest_start_address,
   input  matrix_pkg::dim_t row_size,
   input  matrix_pkg::dim_t col_size,
   input  matrix_pkg::addr_t host_address,
   input  matrix_pkg::elem_t host_writedata,
   input  logic host_write_en,
   output matrix_pkg::elem_t host_readdata
);

   // engine to arbiter
   mem_port_if eng_bus ();

   // arbiter to scratchpad
   mem_port_if ram_bus ();

   // engine owns the memory whenever it is not done
   logic engine_busy;

   assign engine_busy = ~done;

   matrix_relu relu_i (
      .clk                (clk),
      .reset              (reset),
      .start              (start),
      .done               (done),
      .src_start_address  (src_start_address),
      .dest_start_address (dest_start_address),
      .row_size           (row_size),
      .col_size           (col_size),
      .mem                (eng_bus.requester)
   );

   host_port_arbiter arb_i (
      .clk            (clk),
      .reset          (reset),
      .engine_busy    (engine_busy),
      .host_address   (host_address),
      .host_writedata (host_writedata),
      .host_write_en  (host_write_en),
      .host_readdata  (host_readdata),
      .eng            (eng_bus.memory),
      .mem            (ram_bus.requester)
   );

   matrix_scratchpad ram_i (
      .clk (clk),
      .mem (ram_bus.memory)
   );

endmodule

/* verification/matrix_unit_props.sv */
`timescale 1ns/1ns

module matrix_unit_props (
   input logic clk,
   input logic reset,
   input logic start,
   input logic done,
   input matrix_pkg::relu_state_t state,
   input matrix_pkg::dim_t row_q,
   input matrix_pkg::dim_t col_q,
   input logic wr_valid,
   input matrix_pkg::elem_t wr_data_q
);
   import matrix_pkg::*;

   // an idle engine never writes
   idle_no_write: assert property (@(posedge clk) disable iff (reset)
      (state == RELU_IDLE) |-> !wr_valid)
      else $error("wr_en high while the engine is in RELU_IDLE");

   // done mirrors the idle state
   done_is_idle: assert property (@(posedge clk) disable iff (reset)
      done == (state == RELU_IDLE))
      else $error("done does not match the RELU_IDLE state");

   // clamped results only
   no_negative_write: assert property (@(posedge clk) disable iff (reset)
      wr_valid |-> !wr_data_q[DATA_W-1])
      else $error("negative value written by the relu engine");

   // a late start must not reload the sizes
   sizes_held: assert property (@(posedge clk) disable iff (reset)
      (start && (state != RELU_IDLE)) |=> ($stable(row_q) && $stable(col_q)))
      else $error("latched sizes changed by a start while busy");

endmodule

/* verification/matrix_unit_tb.sv */
`timescale 1ns/1ns

module matrix_unit_tb;
   import matrix_pkg::*;

   localparam int RUN_TIMEOUT = 5000;
   localparam int MAX_CASES   = 40;
   localparam int CASE_FIELDS = 6;

   logic  clk;
   logic  reset;
   logic  start;
   logic  done;
   addr_t src_start_address;
   addr_t dest_start_address;
   dim_t  row_size;
   dim_t  col_size;
   addr_t host_address;
   elem_t host_writedata;
   logic  host_write_en;
   elem_t host_readdata;

   // expected scratchpad contents
   elem_t shadow [MEM_DEPTH];

   // raw words of relu_cases.txt, six per case
   logic [15:0] case_mem [256];

   int error_count;
   int check_count;

   matrix_unit_top dut_i (
      .clk                (clk),
      .reset              (reset),
      .start              (start),
      .done               (done),
      .src_start_address  (src_start_address),
      .dest_start_address (dest_start_address),
      .row_size           (row_size),
      .col_size           (col_size),
      .host_address       (host_address),
      .host_writedata     (host_writedata),
      .host_write_en      (host_write_en),
      .host_readdata      (host_readdata)
   );

   bind matrix_relu matrix_unit_props props_i (
      .clk       (clk),
      .reset     (reset),
      .start     (start),
      .done      (done),
      .state     (state),
      .row_q     (row_q),
      .col_q     (col_q),
      .wr_valid  (wr_valid),
      .wr_data_q (wr_data_q)
   );

   always #5 clk = ~clk;

   task automatic check_value(input string name, input logic [15:0] got,
                              input logic [15:0] expected);
      check_count++;
      if (got !== expected) begin
         error_count++;
         $display("ERROR: %s got 0x%h expected 0x%h", name, got, expected);
      end
   endtask

   // negative elements become zero
   function automatic elem_t relu_ref(input elem_t x);
      if (x < 16'sd0) begin
         relu_ref = 16'sd0;
      end else begin
         relu_ref = x;
      end
   endfunction

   function automatic elem_t boundary_value(input int index);
      case (index % 5)
         0: boundary_value = 16'h8000;
         1: boundary_value = 16'hffff;
         2: boundary_value = 16'h0000;
         3: boundary_value = 16'h0001;
         default: boundary_value = 16'h7fff;
      endcase
   endfunction

   // one host write, mirrored in the shadow
   task automatic host_write(input addr_t address, input elem_t data);
      host_address   = address;
      host_writedata = data;
      host_write_en  = 1'b1;
      @(negedge clk);
      host_write_en   = 1'b0;
      shadow[address] = data;
   endtask

   task automatic fill_source(input addr_t src, input int count, input int kind);
      logic [31:0] rnd;
      elem_t value;
      int i;
      for (i = 0; i < count; i++) begin
         rnd = $urandom();
         case (kind)
            1: value = elem_t'({1'b1, rnd[14:0]});
            2: value = boundary_value(i);
            3: value = elem_t'({1'b0, rnd[14:0]});
            default: value = elem_t'(rnd[15:0]);
         endcase
         host_write(src + addr_t'(i), value);
      end
   endtask

   // pipelined sweep, data of the previous address arrives each cycle
   task automatic read_all();
      int a;
      host_write_en = 1'b0;
      host_address  = '0;
      for (a = 1; a <= MEM_DEPTH; a++) begin
         @(negedge clk);
         check_value($sformatf("host_readdata[0x%03h]", a - 1), host_readdata,
                     shadow[addr_t'(a - 1)]);
         if (a < MEM_DEPTH) begin
            host_address = addr_t'(a);
         end
      end
   endtask

   task automatic run_engine(input dim_t rows, input dim_t cols, input addr_t src,
                             input addr_t dest, input int flag, output int busy_cycles);
      src_start_address  = src;
      dest_start_address = dest;
      row_size           = rows;
      col_size           = cols;
      start              = 1'b1;
      @(negedge clk);
      start       = 1'b0;
      busy_cycles = 0;
      while (done !== 1'b1) begin
         if (busy_cycles >= RUN_TIMEOUT) begin
            $display("timeout: done stayed low for %0d cycles after start", RUN_TIMEOUT);
            $display("Simulation finished: FAIL");
            $finish;
         end
         busy_cycles++;
         if (flag != 0) begin
            // junk sweep from the lower guard upwards, all of it must be dropped
            host_address   = dest + addr_t'(busy_cycles % MEM_DEPTH) - addr_t'(2);
            host_writedata = 16'hdead ^ 16'(busy_cycles);
            host_write_en  = 1'b1;
            // second start with other sizes, ignored while busy
            start    = (busy_cycles == 1);
            row_size = ~rows;
            col_size = ~cols;
         end
         @(negedge clk);
      end
      start         = 1'b0;
      host_write_en = 1'b0;
   endtask

   task automatic run_case(input int index);
      elem_t source_words [$];
      dim_t  rows;
      dim_t  cols;
      addr_t src;
      addr_t dest;
      int    kind;
      int    flag;
      int    count;
      int    busy_cycles;
      int    i;
      rows  = dim_t'(case_mem[8'(index * CASE_FIELDS)]);
      cols  = dim_t'(case_mem[8'(index * CASE_FIELDS + 1)]);
      src   = addr_t'(case_mem[8'(index * CASE_FIELDS + 2)]);
      dest  = addr_t'(case_mem[8'(index * CASE_FIELDS + 3)]);
      kind  = int'(case_mem[8'(index * CASE_FIELDS + 4)]);
      flag  = int'(case_mem[8'(index * CASE_FIELDS + 5)]);
      count = int'(rows) * int'(cols);
      $display("case %0d: %0dx%0d src 0x%03h dest 0x%03h fill %0d busy writes %0d",
               index, rows, cols, src, dest, kind, flag);
      // guards just outside the destination
      host_write(dest - addr_t'(1), elem_t'(16'h5a00 ^ {4'h0, dest}));
      host_write(dest + addr_t'(count), elem_t'(16'ha500 ^ {4'h0, dest}));
      fill_source(src, count, kind);
      for (i = 0; i < count; i++) begin
         source_words.push_back(shadow[src + addr_t'(i)]);
      end
      run_engine(rows, cols, src, dest, flag, busy_cycles);
      for (i = 0; i < count; i++) begin
         shadow[dest + addr_t'(i)] = relu_ref(source_words[i]);
      end
      // N+3 cycles of busy, or 2 for an empty matrix
      check_value("done_low_cycles", 16'(busy_cycles),
                  16'((count == 0) ? 2 : count + 3));
      read_all();
   endtask

   initial begin
      int case_count;
      int c;
      clk                = 1'b0;
      reset              = 1'b1;
      start              = 1'b0;
      src_start_address  = '0;
      dest_start_address = '0;
      row_size           = '0;
      col_size           = '0;
      host_address       = '0;
      host_writedata     = '0;
      host_write_en      = 1'b0;
      error_count        = 0;
      check_count        = 0;
      void'($urandom(19));
      for (c = 0; c < 256; c++) begin
         case_mem[8'(c)] = 16'hffff;
      end
      $readmemh("verification/relu_cases.txt", case_mem);

      repeat (16) @(negedge clk);
      reset = 1'b0;
      @(negedge clk);
      check_value("done", 16'(done), 16'h0001);

      // write, then read back one cycle later
      host_write(12'h123, 16'h4c2d);
      @(negedge clk);
      check_value("host_readdata", host_readdata, 16'h4c2d);

      // known contents everywhere
      for (c = 0; c < MEM_DEPTH; c++) begin
         host_write(addr_t'(c), {4'h9, addr_t'(c)});
      end
      read_all();

      case_count = 0;
      while ((case_count < MAX_CASES) &&
             (case_mem[8'(case_count * CASE_FIELDS)] != 16'hffff)) begin
         case_count++;
      end
      if (case_count == 0) begin
         $display("no test cases were read from verification/relu_cases.txt");
         error_count++;
      end
      for (c = 0; c < case_count; c++) begin
         run_case(c);
      end

      $display("cases: %0d, checks: %0d, errors: %0d", case_count, check_count, error_count);
      if (error_count == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

/* verification/relu_cases.txt */
// columns: rows cols src_address dest_address fill flag, all in hex
// fill 0 random, 1 all negative, 2 boundary, 3 all positive; flag 1 host writes while busy
01 01 010 100 0 0
04 04 020 200 0 1
01 05 040 240 2 0
03 0a 060 300 2 1
08 08 400 500 1 0
08 08 600 700 3 1
10 03 800 800 0 0
07 09 880 880 2 1
00 05 900 a00 0 1
05 00 900 a00 0 0
3f 02 b00 c00 0 1
02 3f d00 e00 2 0
06 07 f00 f80 3 0
3f 3f 040 040 0 1

/* tb.f */
hdl/matrix_pkg.sv
hdl/mem_port_if.sv
hdl/matrix_scratchpad.sv
hdl/host_port_arbiter.sv
hdl/matrix_relu.sv
hdl/matrix_unit_top.sv
verification/matrix_unit_props.sv
verification/matrix_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module matrix_unit_tb \
   -Mdir obj_dir -o matrix_unit_sim

sim_output="$(./obj_dir/matrix_unit_sim)" || true
printf '%s\n' "$sim_output"

if grep -qx "Simulation finished: PASS" <<< "$sim_output"; then
   exit 0
fi
exit 1
